/* verilog/ecc90_pkg.sv */
`default_nettype none

package ecc90_pkg;

    // ====================
    // Widths
    // ====================

    localparam int DATA_WIDTH   = 90; // Protected data bits.
    localparam int PARITY_WIDTH = 8;  // Check bits per word.

    // ====================
    // Types
    // ====================

    typedef logic [DATA_WIDTH-1:0]   ecc90_data_t;   // Data word or correction mask.
    typedef logic [PARITY_WIDTH-1:0] ecc90_parity_t; // Check bits or syndrome.

    typedef struct packed {
        logic sbit_err; // Single error in a data or check bit.
        logic dbit_err; // Uncorrectable syndrome.
    } ecc90_status_t;

    // Word as read back from storage in 98 bits.
    typedef struct packed {
        ecc90_data_t   data;
        ecc90_parity_t parity;
    } ecc90_codeword_t;

    typedef ecc90_parity_t ecc90_code_table_t [DATA_WIDTH];

    // ====================
    // Column codes
    // ====================

    // Entry i is the syndrome seen when data bit i flips.
    // Check bit j covers every data bit whose code has bit j set.
    localparam ecc90_code_table_t COLUMN_CODE = '{
        8'b10000011, // Bit 0.
        8'b10000101,
        8'b10000110,
        8'b00000111,
        8'b10001001,
        8'b10001010,
        8'b00001011,
        8'b10001100,
        8'b00001101,
        8'b00001110,
        8'b10001111, // Bit 10.
        8'b10010001,
        8'b10010010,
        8'b00010011,
        8'b10010100,
        8'b00010101,
        8'b00010110,
        8'b10010111,
        8'b10011000,
        8'b00011001,
        8'b00011010, // Bit 20.
        8'b10011011,
        8'b00011100,
        8'b10011101,
        8'b10011110,
        8'b00011111,
        8'b10100001,
        8'b10100010,
        8'b00100011,
        8'b10100100,
        8'b00100101, // Bit 30.
        8'b00100110,
        8'b10100111,
        8'b10101000,
        8'b00101001,
        8'b00101010,
        8'b10101011,
        8'b00101100,
        8'b10101101,
        8'b10101110,
        8'b00101111, // Bit 40.
        8'b10110000,
        8'b00110001,
        8'b00110010,
        8'b10110011,
        8'b00110100,
        8'b10110101,
        8'b10110110,
        8'b00110111,
        8'b00111000,
        8'b10111001, // Bit 50.
        8'b10111010,
        8'b00111011,
        8'b10111100,
        8'b00111101,
        8'b00111110,
        8'b10111111,
        8'b11000001,
        8'b11000010,
        8'b01000011,
        8'b11000100, // Bit 60.
        8'b01000101,
        8'b01000110,
        8'b11000111,
        8'b11001000,
        8'b01001001,
        8'b01001010,
        8'b11001011,
        8'b01001100,
        8'b11001101,
        8'b11001110, // Bit 70.
        8'b01001111,
        8'b11010000,
        8'b01010001,
        8'b01010010,
        8'b11010011,
        8'b01010100,
        8'b11010101,
        8'b11010110,
        8'b01010111,
        8'b01011000, // Bit 80.
        8'b11011001,
        8'b11011010,
        8'b01011011,
        8'b11011100,
        8'b01011101,
        8'b01011110,
        8'b11011111,
        8'b11100000,
        8'b01100001  // Bit 89.
    };

    // ====================
    // Syndrome constants
    // ====================

    localparam ecc90_parity_t SYNDROME_CLEAN = '0; // Stored and fresh check bits agree.

endpackage

`default_nettype wire

/* verilog/ecc90_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module ecc90_encoder (
    input  wire ecc90_pkg::ecc90_data_t data,
    output ecc90_pkg::ecc90_parity_t    parity_out
);

    import ecc90_pkg::*;

    // ====================
    // Check bit sums
    // ====================

    // Each check bit is the XOR of the data bits in its row of the code table.
    always_comb begin
        parity_out = SYNDROME_CLEAN;
        for (int j = 0; j < PARITY_WIDTH; j++) begin
            for (int i = 0; i < DATA_WIDTH; i++) begin
                if (COLUMN_CODE[i][j]) begin
                    parity_out[j] = parity_out[j] ^ data[i]; // Column i joins row j.
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/ecc90_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module ecc90_decoder (
    input  wire ecc90_pkg::ecc90_codeword_t rd_word,
    input  wire ecc90_pkg::ecc90_parity_t   parity_calc,
    input  wire logic                       bypass,
    output ecc90_pkg::ecc90_data_t          data_out,
    output ecc90_pkg::ecc90_data_t          mask,
    output ecc90_pkg::ecc90_status_t        status
);

    import ecc90_pkg::*;

    ecc90_parity_t syndrome;
    ecc90_data_t   col_hit;
    logic          clean;
    logic          data_err;
    logic          chk_err;
    ecc90_status_t raw_status;

    // ====================
    // Syndrome
    // ====================

    assign syndrome = rd_word.parity ^ parity_calc; // Stored against recomputed.
    assign clean    = (syndrome == SYNDROME_CLEAN);

    // ====================
    // Error location
    // ====================

    // Codes are all distinct, so at most one column matches.
    always_comb begin
        col_hit = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            col_hit[i] = (syndrome == COLUMN_CODE[i]);
        end
    end

    assign data_err = |col_hit; // Correctable data bit.

    // A lone set bit points at a check bit and leaves the data alone.
    assign chk_err = !clean && ((syndrome & (syndrome - 1'b1)) == SYNDROME_CLEAN);

    // ====================
    // Classification
    // ====================

    always_comb begin
        raw_status.sbit_err = data_err || chk_err;
        raw_status.dbit_err = !clean && !data_err && !chk_err; // Nothing matched.
    end

    // ====================
    // Outputs
    // ====================

    assign mask = col_hit; // Reported in bypass as well.

    always_comb begin
        if (bypass) begin
            data_out        = rd_word.data; // Raw word passes through.
            status.sbit_err = 1'b0;
            status.dbit_err = 1'b0;
        end else begin
            data_out        = rd_word.data ^ col_hit;
            status.sbit_err = raw_status.sbit_err;
            status.dbit_err = raw_status.dbit_err;
        end
    end

endmodule

`default_nettype wire

/* verilog/ecc90_cal.sv */
`timescale 1ns/1ps
`default_nettype none

module ecc90_cal (
    input  wire ecc90_pkg::ecc90_codeword_t rd_word,
    input  wire logic                       bypass,
    output ecc90_pkg::ecc90_data_t          data_out,
    output ecc90_pkg::ecc90_parity_t        parity_out,
    output ecc90_pkg::ecc90_data_t          mask,
    output ecc90_pkg::ecc90_status_t        status
);

    // ====================
    // Encoder
    // ====================

    // Fresh check bits feed the decoder and the write path.
    ecc90_encoder u_encoder (
        .data       (rd_word.data),
        .parity_out (parity_out)
    );

    // ====================
    // Decoder
    // ====================

    ecc90_decoder u_decoder (
        .rd_word     (rd_word),
        .parity_calc (parity_out), // Compared with the stored bits.
        .bypass      (bypass),
        .data_out    (data_out),
        .mask        (mask),
        .status      (status)
    );

endmodule

`default_nettype wire

/* dv/ecc90_cal_vectors.svh */
`ifndef ECC90_CAL_VECTORS_SVH
`define ECC90_CAL_VECTORS_SVH

// ====================
// Table entry
// ====================

localparam int WORD_WIDTH = DATA_WIDTH + PARITY_WIDTH; // Codeword with check bits at the bottom.

typedef struct packed {
    ecc90_data_t   data;       // Data as written.
    logic          flip_a_en;
    logic [6:0]    flip_a;     // Codeword bit where 0..7 are check bits.
    logic          flip_b_en;
    logic [6:0]    flip_b;
    logic          bypass;
    ecc90_data_t   exp_data;
    ecc90_parity_t exp_parity;
    ecc90_data_t   exp_mask;
    ecc90_status_t exp_status;
} vec_entry_t;

vec_entry_t vectors[$];

// ====================
// Reference model
// ====================

// Sum the column codes of every set data bit.
function automatic ecc90_parity_t model_parity(input ecc90_data_t d);
    ecc90_parity_t p;
    p = '0;
    for (int i = 0; i < DATA_WIDTH; i++) begin
        if (d[i]) begin
            p = p ^ COLUMN_CODE[i];
        end
    end
    return p;
endfunction

// Stored word with its true check bits and the listed flips.
function automatic ecc90_codeword_t build_word(input vec_entry_t e);
    logic [WORD_WIDTH-1:0] flat;
    flat = {e.data, model_parity(e.data)};
    if (e.flip_a_en) begin
        flat[e.flip_a] = ~flat[e.flip_a];
    end
    if (e.flip_b_en) begin
        flat[e.flip_b] = ~flat[e.flip_b];
    end
    return flat;
endfunction

function automatic ecc90_data_t rand_data();
    logic [95:0] r;
    r = {$random(seed), $random(seed), $random(seed)};
    return r[DATA_WIDTH-1:0];
endfunction

function automatic int rand_pos(input int limit);
    return {$random(seed)} % limit;
endfunction

// ====================
// Table builder
// ====================

// A negative index means no flip.
task automatic add_entry(input ecc90_data_t data, input int a, input int b, input logic byp);
    vec_entry_t      e;
    ecc90_codeword_t w;
    int              flips;
    int              idx;
    e           = '0;
    e.data      = data;
    e.flip_a_en = (a >= 0);
    e.flip_a    = a[6:0];
    e.flip_b_en = (b >= 0);
    e.flip_b    = b[6:0];
    e.bypass    = byp;
    w           = build_word(e);
    flips       = e.flip_a_en + e.flip_b_en;
    idx         = (a >= 0) ? a : b;
    if (flips == 1) begin
        e.exp_status.sbit_err = 1'b1;
        if (idx >= PARITY_WIDTH) begin
            e.exp_mask[idx - PARITY_WIDTH] = 1'b1; // Only a data bit sets the mask.
        end
    end else if (flips == 2) begin
        e.exp_status.dbit_err = 1'b1;
    end
    e.exp_parity = model_parity(w.data); // Fresh bits of the data as read.
    e.exp_data   = (flips == 2 || byp) ? w.data : data;
    if (byp) begin
        e.exp_status = '0;
    end
    vectors.push_back(e);
endtask

task automatic build_table();
    int a;
    int b;
    add_entry('0, -1, -1, 1'b0);
    add_entry('1, -1, -1, 1'b0);
    repeat (6) add_entry(rand_data(), -1, -1, 1'b0);
    for (int i = 0; i < DATA_WIDTH; i++) begin
        add_entry(rand_data(), i + PARITY_WIDTH, -1, 1'b0);
    end
    for (int j = 0; j < PARITY_WIDTH; j++) begin
        add_entry(rand_data(), j, -1, 1'b0);
    end
    repeat (24) begin
        a = rand_pos(WORD_WIDTH);
        b = rand_pos(WORD_WIDTH - 1);
        if (b >= a) begin
            b = b + 1; // Keeps the pair distinct.
        end
        add_entry(rand_data(), a, b, 1'b0);
    end
    for (int k = 0; k < 4; k++) begin
        a = rand_pos(WORD_WIDTH);
        b = (a + 1 + rand_pos(WORD_WIDTH - 1)) % WORD_WIDTH;
        add_entry(rand_data(), -1, -1, 1'b1);
        add_entry(rand_data(), a, -1, 1'b1);
        add_entry(rand_data(), a, b, 1'b1);
    end
endtask

`endif

/* dv/ecc90_cal_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ecc90_cal_tb;

    import ecc90_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;

    logic            clk;
    logic            rst_n;
    ecc90_codeword_t rd_word;
    logic            bypass;
    ecc90_data_t     data_out;
    ecc90_parity_t   parity_out;
    ecc90_data_t     mask;
    ecc90_status_t   status;

    integer seed;
    int     pass_count;
    int     fail_count;
    int     cur_test;
    logic   table_ready;

    `include "ecc90_cal_vectors.svh"

    ecc90_cal dut (
        .rd_word    (rd_word),
        .bypass     (bypass),
        .data_out   (data_out),
        .parity_out (parity_out),
        .mask       (mask),
        .status     (status)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

    // ====================
    // Compare tasks
    // ====================

    task automatic check_data(input string name, input ecc90_data_t expected,
                              input ecc90_data_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns test %0d %s expected %h got %h",
                     $time, cur_test, name, expected, actual);
            fail_count++;
        end else begin
            $display("[PASS] %0d ns test %0d %s %h", $time, cur_test, name, actual);
            pass_count++;
        end
    endtask

    task automatic check_parity(input string name, input ecc90_parity_t expected,
                                input ecc90_parity_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns test %0d %s expected %b got %b",
                     $time, cur_test, name, expected, actual);
            fail_count++;
        end else begin
            $display("[PASS] %0d ns test %0d %s %b", $time, cur_test, name, actual);
            pass_count++;
        end
    endtask

    task automatic check_status(input string name, input ecc90_status_t expected,
                                input ecc90_status_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns test %0d %s expected sbit %b dbit %b got sbit %b dbit %b",
                     $time, cur_test, name, expected.sbit_err, expected.dbit_err,
                     actual.sbit_err, actual.dbit_err);
            fail_count++;
        end else begin
            $display("[PASS] %0d ns test %0d %s sbit %b dbit %b", $time, cur_test, name,
                     actual.sbit_err, actual.dbit_err);
            pass_count++;
        end
    endtask

    // ====================
    // Stimulus
    // ====================

    initial begin
        seed        = 32'hf186;
        pass_count  = 0;
        fail_count  = 0;
        cur_test    = 0;
        table_ready = 1'b0;
        rd_word     = '0;
        bypass      = 1'b0;
        build_table();
        table_ready = 1'b1;
        wait (rst_n === 1'b1);
        for (int n = 0; n < vectors.size(); n++) begin
            @(posedge clk);
            cur_test = n;
            rd_word <= build_word(vectors[n]);
            bypass  <= vectors[n].bypass;
            @(negedge clk); // Outputs settled half a cycle after the drive.
            check_data("data_out", vectors[n].exp_data, data_out);
            check_parity("parity_out", vectors[n].exp_parity, parity_out);
            check_data("mask", vectors[n].exp_mask, mask);
            check_status("status", vectors[n].exp_status, status);
        end
        $display("Tests %0d, checks passed %0d, checks failed %0d",
                 vectors.size(), pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // ====================
    // Watchdog
    // ====================

    initial begin
        int limit_ns;
        wait (table_ready === 1'b1);
        limit_ns = (RESET_CYCLES + 2 * vectors.size() + 20) * CLK_PERIOD;
        #(limit_ns);
        $display("Run timed out after %0d ns before all tests were applied", limit_ns);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* ecc90.f */
+incdir+dv
verilog/ecc90_pkg.sv
verilog/ecc90_encoder.sv
verilog/ecc90_decoder.sv
verilog/ecc90_cal.sv
dv/ecc90_cal_tb.sv
